/* axi_slave_fsm.sv */
`timescale 1ns/1ps
/*
 * Single-beat AXI slave state machine
 * Turns AW/W or AR handshakes into system bus strobes
 * and holds the B or R response until the master takes it
 */
module axi_slave_fsm (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // Write address and data
  input  sys_bus_pkg::axi_aw_t  aw_i,
  input  logic                  aw_valid_i,
  output logic                  aw_ready_o,
  input  sys_bus_pkg::axi_w_t   w_i,
  input  logic                  w_valid_i,
  output logic                  w_ready_o,
  // Write response
  output sys_bus_pkg::axi_b_t   b_o,
  output logic                  b_valid_o,
  input  logic                  b_ready_i,
  // Read address and data
  input  sys_bus_pkg::axi_ar_t  ar_i,
  input  logic                  ar_valid_i,
  output logic                  ar_ready_o,
  output sys_bus_pkg::axi_r_t   r_o,
  output logic                  r_valid_o,
  input  logic                  r_ready_i,
  // System bus
  output sys_bus_pkg::sys_req_t req_o,
  input  sys_bus_pkg::sys_rsp_t rsp_i,
  // Timeout counter control
  output logic                  tmo_start_o,
  output logic                  tmo_run_o,
  input  logic                  expire_i
);

  import sys_bus_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WR_STB,
    ST_WR_WAIT,
    ST_WR_RSP,
    ST_RD_STB,
    ST_RD_WAIT,
    ST_RD_RSP
  } state_t;

  state_t    state_q;
  state_t    state_d;
  logic      wr_hs;
  logic      rd_hs;
  logic      in_stb;
  logic      in_wait;
  logic      cap_rsp;
  axi_id_t   id_q;
  sys_addr_t addr_q;
  sys_data_t wdata_q;
  sys_sel_t  sel_q;
  sys_data_t rdata_q;
  axi_resp_t resp_q;

  //////////////////////////////
  // Handshakes
  //////////////////////////////

  // Write needs AW and W together, and wins over a read
  assign wr_hs = (state_q == ST_IDLE) && aw_valid_i && w_valid_i;
  assign rd_hs = (state_q == ST_IDLE) && ar_valid_i && !(aw_valid_i && w_valid_i);

  assign aw_ready_o = wr_hs;
  assign w_ready_o  = wr_hs;
  assign ar_ready_o = rd_hs;

  assign in_stb  = (state_q == ST_WR_STB) || (state_q == ST_RD_STB);
  assign in_wait = (state_q == ST_WR_WAIT) || (state_q == ST_RD_WAIT);

  // Access ends on ack, or on timeout while waiting
  assign cap_rsp = (in_stb && rsp_i.ack) || (in_wait && (rsp_i.ack || expire_i));

  //////////////////////////////
  // State machine
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (wr_hs) begin
          state_d = ST_WR_STB;
        end else if (rd_hs) begin
          state_d = ST_RD_STB;
        end
      end
      ST_WR_STB:  state_d = cap_rsp ? ST_WR_RSP : ST_WR_WAIT;
      ST_WR_WAIT: state_d = cap_rsp ? ST_WR_RSP : ST_WR_WAIT;
      ST_WR_RSP:  state_d = b_ready_i ? ST_IDLE : ST_WR_RSP;
      ST_RD_STB:  state_d = cap_rsp ? ST_RD_RSP : ST_RD_WAIT;
      ST_RD_WAIT: state_d = cap_rsp ? ST_RD_RSP : ST_RD_WAIT;
      ST_RD_RSP:  state_d = r_ready_i ? ST_IDLE : ST_RD_RSP;
      default:    state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request payload, taken at the address handshake
  always_ff @(posedge clk_i) begin
    if (wr_hs) begin
      addr_q  <= aw_i.addr;
      id_q    <= aw_i.id;
      wdata_q <= w_i.data;
      sel_q   <= w_i.strb;
    end else if (rd_hs) begin
      addr_q <= ar_i.addr;
      id_q   <= ar_i.id;
      // Reads always cover the full word
      sel_q  <= '1;
    end
  end

  // Response payload; a real ack beats a late timeout
  always_ff @(posedge clk_i) begin
    if (cap_rsp) begin
      if (rsp_i.ack) begin
        rdata_q <= rsp_i.rdata;
        resp_q  <= rsp_i.err ? RESP_SLVERR : RESP_OKAY;
      end else begin
        rdata_q <= '0;
        resp_q  <= RESP_SLVERR;
      end
    end
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  assign req_o = '{addr: addr_q, wdata: wdata_q, sel: sel_q,
                   wen: (state_q == ST_WR_STB), ren: (state_q == ST_RD_STB)};

  // Timer restarts with the strobe, counts while waiting
  assign tmo_start_o = in_stb;
  assign tmo_run_o   = in_wait;

  assign b_o       = '{id: id_q, resp: resp_q};
  assign b_valid_o = (state_q == ST_WR_RSP);
  assign r_o       = '{id: id_q, data: rdata_q, resp: resp_q, last: 1'b1};
  assign r_valid_o = (state_q == ST_RD_RSP);

endmodule

/* bus_timeout_cnt.sv */
`timescale 1ns/1ps
/*
 * Bus access timeout counter
 * Pulses expire once after TIMEOUT_CYCLES waiting cycles
 */
module bus_timeout_cnt #(
  parameter int unsigned TIMEOUT_CYCLES = 16
) (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic start_i,
  input  logic run_i,
  output logic expire_o
);

  localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

  logic [CNT_W-1:0] cnt_q;
  // Set once expired, held until next start
  logic             done_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q    <= '0;
      done_q   <= 1'b0;
      expire_o <= 1'b0;
    end else begin
      expire_o <= 1'b0;
      if (start_i) begin
        cnt_q  <= '0;
        done_q <= 1'b0;
      end else if (run_i && !done_q) begin
        // Last waiting cycle reached
        if (cnt_q == CNT_W'(TIMEOUT_CYCLES - 1)) begin
          done_q   <= 1'b1;
          expire_o <= 1'b1;
        end
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

endmodule

/* hk_regs.sv */
`timescale 1ns/1ps
/*
 * Housekeeping register slave
 * ID, scratch, LED and GPIO input registers, ack one clock after strobe
 */
module hk_regs #(
  parameter sys_bus_pkg::sys_data_t ID_VALUE = '0
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  sys_bus_pkg::sys_req_t req_i,
  input  sys_bus_pkg::gpio_t    gpio_i,
  output sys_bus_pkg::sys_rsp_t rsp_o,
  output sys_bus_pkg::led_t     led_o
);

  import sys_bus_pkg::*;

  // Register offsets within the slot
  localparam logic [SLOT_LSB-1:0] OFS_ID      = 'h0;
  localparam logic [SLOT_LSB-1:0] OFS_SCRATCH = 'h4;
  localparam logic [SLOT_LSB-1:0] OFS_LED     = 'h8;
  localparam logic [SLOT_LSB-1:0] OFS_GPIO    = 'hC;

  logic [SLOT_LSB-1:0] ofs;
  logic                hit;
  sys_data_t           rd_mux;
  sys_data_t           scratch_q;
  sys_data_t           rdata_q;
  logic                ack_q;
  logic                err_q;

  assign ofs = req_i.addr[SLOT_LSB-1:0];

  //////////////////////////////
  // Read decode
  //////////////////////////////

  always_comb begin
    hit    = 1'b1;
    rd_mux = '0;
    case (ofs)
      OFS_ID:      rd_mux = ID_VALUE;
      OFS_SCRATCH: rd_mux = scratch_q;
      OFS_LED:     rd_mux = sys_data_t'(led_o);
      // GPIO sampled at the read strobe
      OFS_GPIO:    rd_mux = sys_data_t'(gpio_i);
      default:     hit    = 1'b0;
    endcase
  end

  //////////////////////////////
  // Writable registers
  //////////////////////////////

  // Read-only offsets drop the write silently
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      scratch_q <= '0;
      led_o     <= '0;
    end else if (req_i.wen) begin
      if (ofs == OFS_SCRATCH) begin
        for (int i = 0; i < $bits(sys_sel_t); i++) begin
          if (req_i.sel[i]) begin
            scratch_q[8*i +: 8] <= req_i.wdata[8*i +: 8];
          end
        end
      end
      if (ofs == OFS_LED) begin
        led_o <= led_t'(req_i.wdata);
      end
    end
  end

  //////////////////////////////
  // Response
  //////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= req_i.wen || req_i.ren;
      // Unmapped offset
      err_q <= (req_i.wen || req_i.ren) && !hit;
    end
  end

  // Miss reads return zero, writes return zero
  always_ff @(posedge clk_i) begin
    if (req_i.ren) begin
      rdata_q <= rd_mux;
    end else if (req_i.wen) begin
      rdata_q <= '0;
    end
  end

  assign rsp_o = '{rdata: rdata_q, ack: ack_q, err: err_q};

endmodule

/* ps_bus_top.sv */
`timescale 1ns/1ps
/*
 * Programmable-logic side of the processor wrapper
 * AXI slave, bus timeout, slot decoder and two housekeeping slaves
 */
module ps_bus_top #(
  parameter int unsigned            TIMEOUT_CYCLES = 16,
  parameter sys_bus_pkg::sys_data_t ID0_VALUE      = 32'h5250_0001,
  parameter sys_bus_pkg::sys_data_t ID1_VALUE      = 32'h5250_0002
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  // AXI general-purpose port
  input  sys_bus_pkg::axi_aw_t aw_i,
  input  logic                 aw_valid_i,
  output logic                 aw_ready_o,
  input  sys_bus_pkg::axi_w_t  w_i,
  input  logic                 w_valid_i,
  output logic                 w_ready_o,
  output sys_bus_pkg::axi_b_t  b_o,
  output logic                 b_valid_o,
  input  logic                 b_ready_i,
  input  sys_bus_pkg::axi_ar_t ar_i,
  input  logic                 ar_valid_i,
  output logic                 ar_ready_o,
  output sys_bus_pkg::axi_r_t  r_o,
  output logic                 r_valid_o,
  input  logic                 r_ready_i,
  // Housekeeping pins
  input  sys_bus_pkg::gpio_t   gpio_i,
  output sys_bus_pkg::led_t    led0_o,
  output sys_bus_pkg::led_t    led1_o
);

  import sys_bus_pkg::*;

  sys_req_t req;
  sys_rsp_t rsp;
  sys_req_t req0;
  sys_rsp_t rsp0;
  sys_req_t req1;
  sys_rsp_t rsp1;
  logic     tmo_start;
  logic     tmo_run;
  logic     tmo_expire;

  //////////////////////////////
  // AXI slave and timeout
  //////////////////////////////

  axi_slave_fsm u_axi_slave (
    .clk_i      (clk_i),      .arst_n_i   (arst_n_i),
    .aw_i       (aw_i),       .aw_valid_i (aw_valid_i), .aw_ready_o (aw_ready_o),
    .w_i        (w_i),        .w_valid_i  (w_valid_i),  .w_ready_o  (w_ready_o),
    .b_o        (b_o),        .b_valid_o  (b_valid_o),  .b_ready_i  (b_ready_i),
    .ar_i       (ar_i),       .ar_valid_i (ar_valid_i), .ar_ready_o (ar_ready_o),
    .r_o        (r_o),        .r_valid_o  (r_valid_o),  .r_ready_i  (r_ready_i),
    .req_o      (req),        .rsp_i      (rsp),
    .tmo_start_o(tmo_start),  .tmo_run_o  (tmo_run),    .expire_i   (tmo_expire)
  );

  bus_timeout_cnt #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) u_timeout (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .start_i(tmo_start), .run_i(tmo_run), .expire_o(tmo_expire)
  );

  //////////////////////////////
  // Decoder and slaves
  //////////////////////////////

  sys_bus_decoder u_decoder (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .req_i(req), .rsp_o(rsp),
    .req0_o(req0), .rsp0_i(rsp0), .req1_o(req1), .rsp1_i(rsp1)
  );

  // Slot 0
  hk_regs #(.ID_VALUE(ID0_VALUE)) hk0 (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .req_i(req0),
    .gpio_i(gpio_i), .rsp_o(rsp0), .led_o(led0_o)
  );

  // Slot 1, same GPIO pins
  hk_regs #(.ID_VALUE(ID1_VALUE)) hk1 (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .req_i(req1),
    .gpio_i(gpio_i), .rsp_o(rsp1), .led_o(led1_o)
  );

endmodule

/* sys_bus_decoder.sv */
`timescale 1ns/1ps
/*
 * System bus slot decoder
 * Routes strobes by address bits 22..20 to slot 0 or slot 1
 * and returns the response of the slot being accessed
 */
module sys_bus_decoder (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // From the AXI slave
  input  sys_bus_pkg::sys_req_t req_i,
  output sys_bus_pkg::sys_rsp_t rsp_o,
  // Slot 0
  output sys_bus_pkg::sys_req_t req0_o,
  input  sys_bus_pkg::sys_rsp_t rsp0_i,
  // Slot 1
  output sys_bus_pkg::sys_req_t req1_o,
  input  sys_bus_pkg::sys_rsp_t rsp1_i
);

  import sys_bus_pkg::*;

  localparam sys_slot_t SLOT_HK0 = 3'd0;
  localparam sys_slot_t SLOT_HK1 = 3'd1;

  sys_slot_t slot;
  sys_slot_t slot_q;
  sys_req_t  fwd;
  logic      sel0;
  logic      sel1;

  //////////////////////////////
  // Request path
  //////////////////////////////

  assign slot = req_i.addr[SLOT_MSB:SLOT_LSB];
  assign sel0 = (slot == SLOT_HK0);
  assign sel1 = (slot == SLOT_HK1);

  // Slaves see only their offset
  always_comb begin
    fwd = req_i;
    fwd.addr[SLOT_MSB:SLOT_LSB] = '0;
  end

  // Address and data go everywhere, strobes only to the hit slot
  always_comb begin
    req0_o     = fwd;
    req0_o.wen = fwd.wen && sel0;
    req0_o.ren = fwd.ren && sel0;
    req1_o     = fwd;
    req1_o.wen = fwd.wen && sel1;
    req1_o.ren = fwd.ren && sel1;
  end

  //////////////////////////////
  // Response path
  //////////////////////////////

  // Slot of the access in flight
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      slot_q <= SLOT_HK0;
    end else if (req_i.wen || req_i.ren) begin
      slot_q <= slot;
    end
  end

  // Empty slots stay silent, the timeout closes them
  always_comb begin
    case (slot_q)
      SLOT_HK0: rsp_o = rsp0_i;
      SLOT_HK1: rsp_o = rsp1_i;
      default:  rsp_o = '0;
    endcase
  end

endmodule

/* sys_bus_pkg.sv */
/*
 * Shared widths and channel types for the processor bus subsystem
 * AXI single-beat channel structs, system bus request and response
 */
package sys_bus_pkg;

  //////////////////////////////
  // Plain widths
  //////////////////////////////

  // Byte address on AXI and system bus
  typedef logic [31:0] sys_addr_t;
  // Bus data word
  typedef logic [31:0] sys_data_t;
  // One strobe per data byte
  typedef logic [3:0]  sys_sel_t;
  // Slot number from address bits 22..20
  typedef logic [2:0]  sys_slot_t;
  typedef logic [11:0] axi_id_t;
  typedef logic [1:0]  axi_resp_t;
  typedef logic [7:0]  led_t;
  typedef logic [23:0] gpio_t;

  // Slot field position in the address
  localparam int SLOT_MSB = 22;
  localparam int SLOT_LSB = 20;

  // AXI response codes in use
  localparam axi_resp_t RESP_OKAY   = 2'd0;
  localparam axi_resp_t RESP_SLVERR = 2'd2;

  //////////////////////////////
  // AXI channels
  //////////////////////////////

  typedef struct packed {
    sys_addr_t addr;
    axi_id_t   id;
  } axi_aw_t;

  typedef struct packed {
    sys_addr_t addr;
    axi_id_t   id;
  } axi_ar_t;

  typedef struct packed {
    sys_data_t data;
    sys_sel_t  strb;
  } axi_w_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } axi_b_t;

  // Single beat only, last always high
  typedef struct packed {
    axi_id_t   id;
    sys_data_t data;
    axi_resp_t resp;
    logic      last;
  } axi_r_t;

  //////////////////////////////
  // System bus
  //////////////////////////////

  // Strobes are one cycle, payload held for the access
  typedef struct packed {
    sys_addr_t addr;
    sys_data_t wdata;
    sys_sel_t  sel;
    logic      wen;
    logic      ren;
  } sys_req_t;

  // err and rdata qualified by ack
  typedef struct packed {
    sys_data_t rdata;
    logic      ack;
    logic      err;
  } sys_rsp_t;

endpackage

/* tb_ps_bus_top.sv */
`timescale 1ns/1ps
/*
 * Random-stimulus testbench for the processor bus subsystem
 * AXI write and read driver tasks, scratch and LED model per slot,
 * typed compare tasks and a cycle limit
 */
module tb_ps_bus_top;

  import sys_bus_pkg::*;

  localparam int unsigned TIMEOUT_CYCLES = 16;
  localparam sys_data_t   ID0_VALUE      = 32'h5250_0001;
  localparam sys_data_t   ID1_VALUE      = 32'h5250_0002;
  // 300 accesses, each bounded by the bus timeout plus handshake slack
  localparam int          CYCLE_LIMIT    = 300 * (TIMEOUT_CYCLES + 40);

  logic      clk_i;
  logic      arst_n_i;
  axi_aw_t   aw;
  logic      aw_valid;
  logic      aw_ready_o;
  axi_w_t    w;
  logic      w_valid;
  logic      w_ready_o;
  axi_b_t    b_o;
  logic      b_valid_o;
  logic      b_ready;
  axi_ar_t   ar;
  logic      ar_valid;
  logic      ar_ready_o;
  axi_r_t    r_o;
  logic      r_valid_o;
  logic      r_ready;
  gpio_t     gpio;
  led_t      led0_o;
  led_t      led1_o;

  integer    seed;
  int        cycles;
  // Model state per slot
  sys_data_t scratch_m [2];
  led_t      led_m [2];

  ps_bus_top #(
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES),
    .ID0_VALUE     (ID0_VALUE),
    .ID1_VALUE     (ID1_VALUE)
  ) dut (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .aw_i(aw), .aw_valid_i(aw_valid), .aw_ready_o(aw_ready_o),
    .w_i(w), .w_valid_i(w_valid), .w_ready_o(w_ready_o),
    .b_o(b_o), .b_valid_o(b_valid_o), .b_ready_i(b_ready),
    .ar_i(ar), .ar_valid_i(ar_valid), .ar_ready_o(ar_ready_o),
    .r_o(r_o), .r_valid_o(r_valid_o), .r_ready_i(r_ready),
    .gpio_i(gpio), .led0_o(led0_o), .led1_o(led1_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Error handling
  //////////////////////////////

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_data(input string name, input sys_data_t exp, input sys_data_t act);
    if (exp !== act) begin
      $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_t exp, input axi_resp_t act);
    if (exp !== act) begin
      $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_led(input string name, input led_t exp, input led_t act);
    if (exp !== act) begin
      $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_id(input string name, input axi_id_t exp, input axi_id_t act);
    if (exp !== act) begin
      $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  // Run limit
  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Run did not finish within %0d clock cycles", CYCLE_LIMIT);
      abort_run();
    end
  end

  //////////////////////////////
  // Model helpers
  //////////////////////////////

  function automatic sys_addr_t make_addr(input sys_slot_t slot, input logic [19:0] ofs);
    return {9'd0, slot, ofs};
  endfunction

  // Old byte kept where the strobe is low
  function automatic sys_data_t merge_bytes(input sys_data_t old, input sys_data_t nw,
                                            input sys_sel_t strb);
    sys_data_t res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) res[8*i +: 8] = nw[8*i +: 8];
    end
    return res;
  endfunction

  //////////////////////////////
  // AXI driver tasks
  //////////////////////////////

  task automatic axi_write(input sys_addr_t addr, input sys_data_t data, input sys_sel_t strb,
                           output axi_resp_t resp);
    axi_id_t id;
    axi_b_t  first;
    logic    seen;
    logic    done;
    int      stall;
    id    = axi_id_t'($random(seed));
    stall = {$random(seed)} % 6;
    repeat ({$random(seed)} % 4) @(negedge clk_i);
    aw       = '{addr: addr, id: id};
    w        = '{data: data, strb: strb};
    aw_valid = 1'b1;
    w_valid  = 1'b1;
    #1;
    while (!(aw_ready_o && w_ready_o)) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    aw_valid = 1'b0;
    w_valid  = 1'b0;
    seen     = 1'b0;
    done     = 1'b0;
    // Hold bready low for a random stretch once B shows up
    while (!done) begin
      b_ready = (stall == 0);
      #1;
      if (b_valid_o) begin
        if (!seen) begin
          first = b_o;
          seen  = 1'b1;
        end else begin
          check_id("b_o.id", first.id, b_o.id);
          check_resp("b_o.resp", first.resp, b_o.resp);
        end
        if (b_ready) done = 1'b1;
        else stall--;
      end
      @(negedge clk_i);
    end
    b_ready = 1'b0;
    check_id("b_o.id", id, first.id);
    resp = first.resp;
  endtask

  task automatic axi_read(input sys_addr_t addr, output sys_data_t data,
                          output axi_resp_t resp);
    axi_id_t id;
    axi_r_t  first;
    logic    seen;
    logic    done;
    int      stall;
    id    = axi_id_t'($random(seed));
    stall = {$random(seed)} % 6;
    repeat ({$random(seed)} % 4) @(negedge clk_i);
    ar       = '{addr: addr, id: id};
    ar_valid = 1'b1;
    #1;
    while (!ar_ready_o) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    ar_valid = 1'b0;
    seen     = 1'b0;
    done     = 1'b0;
    while (!done) begin
      r_ready = (stall == 0);
      #1;
      if (r_valid_o) begin
        if (!seen) begin
          first = r_o;
          seen  = 1'b1;
        end else begin
          check_id("r_o.id", first.id, r_o.id);
          check_data("r_o.data", first.data, r_o.data);
          check_resp("r_o.resp", first.resp, r_o.resp);
        end
        if (r_ready) done = 1'b1;
        else stall--;
      end
      @(negedge clk_i);
    end
    r_ready = 1'b0;
    check_id("r_o.id", id, first.id);
    // Single beat, so every R response is the last one
    if (first.last !== 1'b1) begin
      $display("Read response arrived with last not set at t=%0t", $time);
      abort_run();
    end
    data = first.data;
    resp = first.resp;
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    sys_data_t   rdata;
    sys_data_t   wdata;
    sys_sel_t    strb;
    axi_resp_t   resp;
    sys_slot_t   s;
    logic [19:0] ofs;
    seed     = 32'h45b9_7804;
    cycles   = 0;
    arst_n_i = 1'b0;
    aw       = '0;
    w        = '0;
    ar       = '0;
    aw_valid = 1'b0;
    w_valid  = 1'b0;
    ar_valid = 1'b0;
    b_ready  = 1'b0;
    r_ready  = 1'b0;
    gpio     = '0;
    for (int i = 0; i < 2; i++) begin
      scratch_m[i] = '0;
      led_m[i]     = '0;
    end
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    if (aw_ready_o || w_ready_o || ar_ready_o || b_valid_o || r_valid_o) begin
      $display("AXI handshake outputs are not low after reset");
      abort_run();
    end
    check_led("led0_o", 8'h00, led0_o);
    check_led("led1_o", 8'h00, led1_o);

    // ID words stay unchanged after a write to the ID offset
    for (int i = 0; i < 2; i++) begin
      axi_read(make_addr(sys_slot_t'(i), 20'h0), rdata, resp);
      check_data("id word", (i == 0) ? ID0_VALUE : ID1_VALUE, rdata);
      check_resp("r_o.resp", RESP_OKAY, resp);
      axi_write(make_addr(sys_slot_t'(i), 20'h0), $random(seed), 4'hF, resp);
      check_resp("b_o.resp", RESP_OKAY, resp);
      axi_read(make_addr(sys_slot_t'(i), 20'h0), rdata, resp);
      check_data("id word", (i == 0) ? ID0_VALUE : ID1_VALUE, rdata);
    end

    // Scratch with byte strobes
    for (int i = 0; i < 40; i++) begin
      s     = sys_slot_t'({$random(seed)} % 2);
      wdata = $random(seed);
      strb  = sys_sel_t'($random(seed));
      axi_write(make_addr(s, 20'h4), wdata, strb, resp);
      check_resp("b_o.resp", RESP_OKAY, resp);
      scratch_m[s] = merge_bytes(scratch_m[s], wdata, strb);
      axi_read(make_addr(s, 20'h4), rdata, resp);
      check_data("scratch", scratch_m[s], rdata);
      check_resp("r_o.resp", RESP_OKAY, resp);
    end

    // LED register and pins
    for (int i = 0; i < 20; i++) begin
      s     = sys_slot_t'({$random(seed)} % 2);
      wdata = $random(seed);
      axi_write(make_addr(s, 20'h8), wdata, 4'hF, resp);
      check_resp("b_o.resp", RESP_OKAY, resp);
      led_m[s] = wdata[7:0];
      check_led("led0_o", led_m[0], led0_o);
      check_led("led1_o", led_m[1], led1_o);
      axi_read(make_addr(s, 20'h8), rdata, resp);
      check_data("led reg", {24'd0, led_m[s]}, rdata);
      check_resp("r_o.resp", RESP_OKAY, resp);
    end

    // GPIO input held steady for the whole access
    for (int i = 0; i < 10; i++) begin
      gpio = gpio_t'($random(seed));
      s    = sys_slot_t'({$random(seed)} % 2);
      axi_read(make_addr(s, 20'hC), rdata, resp);
      check_data("gpio reg", {8'd0, gpio}, rdata);
      check_resp("r_o.resp", RESP_OKAY, resp);
    end

    // Empty slots and unmapped offsets followed by a good access
    for (int i = 0; i < 20; i++) begin
      if ({$random(seed)} % 2) begin
        s   = sys_slot_t'(2 + {$random(seed)} % 6);
        ofs = 20'(4 * ({$random(seed)} % 4));
      end else begin
        s   = sys_slot_t'({$random(seed)} % 2);
        ofs = (20'h10 + 20'({$random(seed)} % 20'hFFF0)) & 20'hFFFFC;
      end
      if ({$random(seed)} % 2) begin
        axi_write(make_addr(s, ofs), $random(seed), 4'hF, resp);
        check_resp("b_o.resp", RESP_SLVERR, resp);
      end else begin
        axi_read(make_addr(s, ofs), rdata, resp);
        check_resp("r_o.resp", RESP_SLVERR, resp);
        check_data("error read", 32'h0, rdata);
      end
      s = sys_slot_t'({$random(seed)} % 2);
      axi_read(make_addr(s, 20'h4), rdata, resp);
      check_data("scratch", scratch_m[s], rdata);
      check_resp("r_o.resp", RESP_OKAY, resp);
      check_led("led0_o", led_m[0], led0_o);
      check_led("led1_o", led_m[1], led1_o);
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule

/* vlog.f */
sys_bus_pkg.sv
axi_slave_fsm.sv
bus_timeout_cnt.sv
sys_bus_decoder.sv
hk_regs.sv
ps_bus_top.sv
tb_ps_bus_top.sv
